// File: hw/cpuPkg.sv
package cpuPkg;

  // data and instruction words
  typedef logic [15:0] word_t;
  typedef logic [15:0] instr_t;
  typedef logic [2:0]  regAddr_t;

  // zero in bit 2, negative in bit 1, carry in bit 0
  typedef logic [2:0]  ccr_t;

  parameter int ccrZero  = 2;
  parameter int ccrNeg   = 1;
  parameter int ccrCarry = 0;

  typedef enum logic [4:0] {
    opNop, opAdd, opSub, opAnd, opOr, opNot, opInc, opMov,
    opShl, opShr, opLdi, opIn, opOut, opLoad, opStore, opHalt
  } opcode_t;

  typedef enum logic [3:0] {
    aluPass, aluAdd, aluSub, aluAnd, aluOr, aluNot, aluInc, aluShl, aluShr
  } aluOp_t;

  typedef enum logic [1:0] {
    fetchIdle, fetchRunning, fetchHalted
  } fetchState_t;

  // instruction field positions
  parameter int opcodeHi = 15;
  parameter int opcodeLo = 11;
  parameter int destHi   = 10;
  parameter int destLo   = 8;
  parameter int srcAHi   = 7;
  parameter int srcALo   = 5;
  parameter int srcBHi   = 4;
  parameter int srcBLo   = 2;
  parameter int immHi    = 7;
  parameter int immLo    = 0;
  parameter int shiftHi  = 3;
  parameter int shiftLo  = 0;

endpackage

// File: hw/regFile.sv
`timescale 1ns/10ps

module regFile (
  input  logic             clk,
  input  logic             rst,
  input  cpuPkg::regAddr_t readAddrA,
  input  cpuPkg::regAddr_t readAddrB,
  output cpuPkg::word_t    readDataA,
  output cpuPkg::word_t    readDataB,
  input  logic             writeEnable,
  input  cpuPkg::regAddr_t writeAddr,
  input  cpuPkg::word_t    writeData
);

  cpuPkg::word_t regs [8];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < 8; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (writeEnable)
    begin
      regs[writeAddr] <= writeData;
    end
  end

  // same-cycle write shows through on both ports
  assign readDataA = (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
  assign readDataB = (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

// File: hw/fetchStage.sv
`timescale 1ns/10ps

module fetchStage #(
  parameter int imemAddrWidth = 8
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  logic                     progWrite,
  input  logic [imemAddrWidth-1:0] progAddr,
  input  cpuPkg::instr_t           progData,
  input  logic                     haltDecoded,
  output cpuPkg::instr_t           instr,
  output logic                     instrValid,
  output logic                     halted
);

  cpuPkg::instr_t imem [2**imemAddrWidth];
  cpuPkg::fetchState_t state;
  logic [imemAddrWidth-1:0] pc;

  // loader writes land only while fetch is idle
  always_ff @(posedge clk)
  begin
    if (progWrite && state == cpuPkg::fetchIdle)
    begin
      imem[progAddr] <= progData;
    end
  end

  // run/halt control and program counter
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state      <= cpuPkg::fetchIdle;
      pc         <= '0;
      instrValid <= 1'b0;
    end
    else
    begin
      case (state)
        cpuPkg::fetchIdle:
        begin
          instrValid <= 1'b0;
          if (start)
          begin
            state <= cpuPkg::fetchRunning;
            pc    <= '0;
          end
        end
        cpuPkg::fetchRunning:
        begin
          // stop issuing as soon as decode sees halt
          if (haltDecoded)
          begin
            state      <= cpuPkg::fetchHalted;
            instrValid <= 1'b0;
          end
          else
          begin
            instrValid <= 1'b1;
            pc         <= pc + 1'b1;
          end
        end
        default:
        begin
          instrValid <= 1'b0;
        end
      endcase
    end
  end

  // fetch register payload
  always_ff @(posedge clk)
  begin
    instr <= imem[pc];
  end

  assign halted = (state == cpuPkg::fetchHalted);

  // program must not change under a running fetch
  assert property (@(posedge clk) disable iff (rst)
    state == cpuPkg::fetchRunning |-> !progWrite);

endmodule

// File: hw/decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
  input  logic             clk,
  input  logic             rst,
  input  cpuPkg::instr_t   instr,
  input  logic             instrValid,
  input  logic             wbWrite,
  input  cpuPkg::regAddr_t wbAddr,
  input  cpuPkg::word_t    wbData,
  output logic             haltDecoded,
  output logic             exValid,
  output logic             useInput,
  output logic             memRead,
  output logic             memWrite,
  output logic             regWrite,
  output logic             outWrite,
  output logic             halt,
  output cpuPkg::aluOp_t   aluOp,
  output cpuPkg::word_t    operandA,
  output cpuPkg::word_t    operandB,
  output logic [3:0]       shiftAmount,
  output cpuPkg::regAddr_t writeAddr
);

  cpuPkg::opcode_t  opcode;
  cpuPkg::regAddr_t destField;
  cpuPkg::regAddr_t srcAField;
  cpuPkg::regAddr_t srcBField;
  cpuPkg::regAddr_t readAddrB;
  logic [7:0]       immField;
  logic [3:0]       shiftField;
  cpuPkg::word_t    readDataA;
  cpuPkg::word_t    readDataB;
  cpuPkg::aluOp_t   aluOpNext;
  logic useInputNext;
  logic memReadNext;
  logic memWriteNext;
  logic regWriteNext;
  logic outWriteNext;
  logic haltNext;
  logic useImm;
  logic bFromA;
  logic knownOp;

  // instruction fields
  assign opcode     = cpuPkg::opcode_t'(instr[cpuPkg::opcodeHi:cpuPkg::opcodeLo]);
  assign destField  = instr[cpuPkg::destHi:cpuPkg::destLo];
  assign srcAField  = instr[cpuPkg::srcAHi:cpuPkg::srcALo];
  assign srcBField  = instr[cpuPkg::srcBHi:cpuPkg::srcBLo];
  assign immField   = instr[cpuPkg::immHi:cpuPkg::immLo];
  assign shiftField = instr[cpuPkg::shiftHi:cpuPkg::shiftLo];

  // mov and out route the first source through port B, since pass forwards B
  assign readAddrB = bFromA ? srcAField : srcBField;

  regFile i_regFile (
    .clk         (clk),
    .rst         (rst),
    .readAddrA   (srcAField),
    .readAddrB   (readAddrB),
    .readDataA   (readDataA),
    .readDataB   (readDataB),
    .writeEnable (wbWrite),
    .writeAddr   (wbAddr),
    .writeData   (wbData)
  );

  // an invalid slot decodes as nop
  always_comb
  begin
    aluOpNext    = cpuPkg::aluPass;
    useInputNext = 1'b0;
    memReadNext  = 1'b0;
    memWriteNext = 1'b0;
    regWriteNext = 1'b0;
    outWriteNext = 1'b0;
    haltNext     = 1'b0;
    useImm       = 1'b0;
    bFromA       = 1'b0;
    knownOp      = 1'b1;
    if (instrValid)
    begin
      case (opcode)
        cpuPkg::opNop:   knownOp = 1'b1;
        cpuPkg::opAdd:
        begin
          aluOpNext    = cpuPkg::aluAdd;
          regWriteNext = 1'b1;
        end
        cpuPkg::opSub:
        begin
          aluOpNext    = cpuPkg::aluSub;
          regWriteNext = 1'b1;
        end
        cpuPkg::opAnd:
        begin
          aluOpNext    = cpuPkg::aluAnd;
          regWriteNext = 1'b1;
        end
        cpuPkg::opOr:
        begin
          aluOpNext    = cpuPkg::aluOr;
          regWriteNext = 1'b1;
        end
        cpuPkg::opNot:
        begin
          aluOpNext    = cpuPkg::aluNot;
          regWriteNext = 1'b1;
        end
        cpuPkg::opInc:
        begin
          aluOpNext    = cpuPkg::aluInc;
          regWriteNext = 1'b1;
        end
        cpuPkg::opShl:
        begin
          aluOpNext    = cpuPkg::aluShl;
          regWriteNext = 1'b1;
        end
        cpuPkg::opShr:
        begin
          aluOpNext    = cpuPkg::aluShr;
          regWriteNext = 1'b1;
        end
        cpuPkg::opMov:
        begin
          bFromA       = 1'b1;
          regWriteNext = 1'b1;
        end
        cpuPkg::opLdi:
        begin
          useImm       = 1'b1;
          regWriteNext = 1'b1;
        end
        cpuPkg::opIn:
        begin
          useInputNext = 1'b1;
          regWriteNext = 1'b1;
        end
        cpuPkg::opOut:
        begin
          bFromA       = 1'b1;
          outWriteNext = 1'b1;
        end
        cpuPkg::opLoad:
        begin
          memReadNext  = 1'b1;
          regWriteNext = 1'b1;
        end
        cpuPkg::opStore: memWriteNext = 1'b1;
        cpuPkg::opHalt:  haltNext = 1'b1;
        default:         knownOp = 1'b0;
      endcase
    end
  end

  // combinational path back to fetch
  assign haltDecoded = haltNext;

  // decode to execute control
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      exValid  <= 1'b0;
      aluOp    <= cpuPkg::aluPass;
      useInput <= 1'b0;
      memRead  <= 1'b0;
      memWrite <= 1'b0;
      regWrite <= 1'b0;
      outWrite <= 1'b0;
      halt     <= 1'b0;
    end
    else
    begin
      exValid  <= instrValid;
      aluOp    <= aluOpNext;
      useInput <= useInputNext;
      memRead  <= memReadNext;
      memWrite <= memWriteNext;
      regWrite <= regWriteNext;
      outWrite <= outWriteNext;
      halt     <= haltNext;
    end
  end

  // operands and destination
  always_ff @(posedge clk)
  begin
    operandA    <= readDataA;
    operandB    <= useImm ? {8'h00, immField} : readDataB;
    shiftAmount <= shiftField;
    writeAddr   <= destField;
  end

  // opcode outside the set reaching decode
  assert property (@(posedge clk) disable iff (rst) instrValid |-> knownOp);

endmodule

// File: hw/executeStage.sv
`timescale 1ns/10ps

module executeStage (
  input  logic             clk,
  input  logic             rst,
  input  logic             exValid,
  input  cpuPkg::aluOp_t   aluOp,
  input  cpuPkg::word_t    operandA,
  input  cpuPkg::word_t    operandB,
  input  logic [3:0]       shiftAmount,
  input  logic             useInput,
  input  logic             exMemRead,
  input  logic             exMemWrite,
  input  logic             exRegWrite,
  input  cpuPkg::regAddr_t exWriteAddr,
  input  logic             exOutWrite,
  input  logic             halt,
  input  cpuPkg::word_t    inputPort,
  output cpuPkg::ccr_t     ccr,
  output logic             resValid,
  output logic             memRead,
  output logic             memWrite,
  output logic             regWrite,
  output logic             outWrite,
  output cpuPkg::word_t    result,
  output cpuPkg::word_t    storeData,
  output cpuPkg::regAddr_t writeAddr
);

  logic [16:0]   wide;
  cpuPkg::word_t aluResult;
  cpuPkg::word_t resultNext;
  logic          carry;
  logic          ccrUpdate;

  // ALU
  always_comb
  begin
    wide      = '0;
    aluResult = operandB;
    carry     = 1'b0;
    case (aluOp)
      cpuPkg::aluAdd:
      begin
        wide      = {1'b0, operandA} + {1'b0, operandB};
        aluResult = wide[15:0];
        carry     = wide[16];
      end
      cpuPkg::aluSub:
      begin
        // bit 16 of the wide difference is the borrow
        wide      = {1'b0, operandA} - {1'b0, operandB};
        aluResult = wide[15:0];
        carry     = wide[16];
      end
      cpuPkg::aluAnd: aluResult = operandA & operandB;
      cpuPkg::aluOr:  aluResult = operandA | operandB;
      cpuPkg::aluNot: aluResult = ~operandA;
      cpuPkg::aluInc: aluResult = operandA + 16'd1;
      cpuPkg::aluShl:
      begin
        // last bit out lands in bit 16, zero for a shift of 0
        wide      = {1'b0, operandA} << shiftAmount;
        aluResult = wide[15:0];
        carry     = wide[16];
      end
      cpuPkg::aluShr: aluResult = operandA >> shiftAmount;
      default:        aluResult = operandB;
    endcase
  end

  // flags only for real ALU work, not mov, ldi, in or load
  assign ccrUpdate = exValid && exRegWrite && !useInput && !exMemRead &&
                     aluOp != cpuPkg::aluPass;

  // in takes the port, memory ops carry the address in A
  assign resultNext = useInput ? inputPort :
                      (exMemRead || exMemWrite) ? operandA : aluResult;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ccr      <= '0;
      resValid <= 1'b0;
      memRead  <= 1'b0;
      memWrite <= 1'b0;
      regWrite <= 1'b0;
      outWrite <= 1'b0;
    end
    else
    begin
      if (ccrUpdate)
      begin
        ccr[cpuPkg::ccrZero]  <= (aluResult == 16'h0000);
        ccr[cpuPkg::ccrNeg]   <= aluResult[15];
        ccr[cpuPkg::ccrCarry] <= carry;
      end
      // halt has nothing left to do past here
      resValid <= exValid && !halt;
      memRead  <= exValid && exMemRead;
      memWrite <= exValid && exMemWrite;
      regWrite <= exValid && exRegWrite;
      outWrite <= exValid && exOutWrite;
    end
  end

  // result payload
  always_ff @(posedge clk)
  begin
    result    <= resultNext;
    storeData <= operandB;
    writeAddr <= exWriteAddr;
  end

  // load and store are distinct opcodes
  assert property (@(posedge clk) disable iff (rst) exValid |-> !(exMemRead && exMemWrite));

endmodule

// File: hw/resultStage.sv
`timescale 1ns/10ps

module resultStage #(
  parameter int dmemAddrWidth = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             resValid,
  input  cpuPkg::word_t    result,
  input  cpuPkg::word_t    storeData,
  input  logic             memRead,
  input  logic             memWrite,
  input  logic             regWrite,
  input  cpuPkg::regAddr_t writeAddr,
  input  logic             outWrite,
  output logic             wbWrite,
  output cpuPkg::regAddr_t wbAddr,
  output cpuPkg::word_t    wbData,
  output cpuPkg::word_t    outputPort,
  output logic             outStrobe
);

  cpuPkg::word_t dmem [2**dmemAddrWidth];
  logic [dmemAddrWidth-1:0] dmemAddr;

  // low bits of the register address
  assign dmemAddr = result[dmemAddrWidth-1:0];

  always_ff @(posedge clk)
  begin
    if (resValid && memWrite)
    begin
      dmem[dmemAddr] <= storeData;
    end
  end

  // load data is read within the result cycle
  assign wbWrite = resValid && regWrite;
  assign wbAddr  = writeAddr;
  assign wbData  = memRead ? dmem[dmemAddr] : result;

  // output port with single-cycle strobe
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      outputPort <= '0;
      outStrobe  <= 1'b0;
    end
    else
    begin
      outStrobe <= resValid && outWrite;
      if (resValid && outWrite)
      begin
        outputPort <= result;
      end
    end
  end

endmodule

// File: hw/processor.sv
`timescale 1ns/10ps

module processor #(
  parameter int imemAddrWidth = 8,
  parameter int dmemAddrWidth = 8
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  logic                     progWrite,
  input  logic [imemAddrWidth-1:0] progAddr,
  input  cpuPkg::instr_t           progData,
  input  cpuPkg::word_t            inputPort,
  output cpuPkg::word_t            outputPort,
  output logic                     outStrobe,
  output cpuPkg::ccr_t             ccr,
  output logic                     halted
);

  // fetch to decode
  cpuPkg::instr_t   fetchInstr;
  logic             fetchValid;
  logic             haltDecoded;

  // decode to execute
  logic             decExValid;
  logic             decUseInput;
  logic             decMemRead;
  logic             decMemWrite;
  logic             decRegWrite;
  logic             decOutWrite;
  logic             decHalt;
  cpuPkg::aluOp_t   decAluOp;
  cpuPkg::word_t    decOperandA;
  cpuPkg::word_t    decOperandB;
  logic [3:0]       decShiftAmount;
  cpuPkg::regAddr_t decWriteAddr;

  // execute to result
  logic             resValid;
  logic             resMemRead;
  logic             resMemWrite;
  logic             resRegWrite;
  logic             resOutWrite;
  cpuPkg::word_t    resResult;
  cpuPkg::word_t    resStoreData;
  cpuPkg::regAddr_t resWriteAddr;

  // write-back into the register file
  logic             wbWrite;
  cpuPkg::regAddr_t wbAddr;
  cpuPkg::word_t    wbData;

  fetchStage #(
    .imemAddrWidth (imemAddrWidth)
  ) i_fetchStage (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .progWrite   (progWrite),
    .progAddr    (progAddr),
    .progData    (progData),
    .haltDecoded (haltDecoded),
    .instr       (fetchInstr),
    .instrValid  (fetchValid),
    .halted      (halted)
  );

  decodeStage i_decodeStage (
    .clk         (clk),
    .rst         (rst),
    .instr       (fetchInstr),
    .instrValid  (fetchValid),
    .wbWrite     (wbWrite),
    .wbAddr      (wbAddr),
    .wbData      (wbData),
    .haltDecoded (haltDecoded),
    .exValid     (decExValid),
    .useInput    (decUseInput),
    .memRead     (decMemRead),
    .memWrite    (decMemWrite),
    .regWrite    (decRegWrite),
    .outWrite    (decOutWrite),
    .halt        (decHalt),
    .aluOp       (decAluOp),
    .operandA    (decOperandA),
    .operandB    (decOperandB),
    .shiftAmount (decShiftAmount),
    .writeAddr   (decWriteAddr)
  );

  executeStage i_executeStage (
    .clk         (clk),
    .rst         (rst),
    .exValid     (decExValid),
    .aluOp       (decAluOp),
    .operandA    (decOperandA),
    .operandB    (decOperandB),
    .shiftAmount (decShiftAmount),
    .useInput    (decUseInput),
    .exMemRead   (decMemRead),
    .exMemWrite  (decMemWrite),
    .exRegWrite  (decRegWrite),
    .exWriteAddr (decWriteAddr),
    .exOutWrite  (decOutWrite),
    .halt        (decHalt),
    .inputPort   (inputPort),
    .ccr         (ccr),
    .resValid    (resValid),
    .memRead     (resMemRead),
    .memWrite    (resMemWrite),
    .regWrite    (resRegWrite),
    .outWrite    (resOutWrite),
    .result      (resResult),
    .storeData   (resStoreData),
    .writeAddr   (resWriteAddr)
  );

  resultStage #(
    .dmemAddrWidth (dmemAddrWidth)
  ) i_resultStage (
    .clk        (clk),
    .rst        (rst),
    .resValid   (resValid),
    .result     (resResult),
    .storeData  (resStoreData),
    .memRead    (resMemRead),
    .memWrite   (resMemWrite),
    .regWrite   (resRegWrite),
    .writeAddr  (resWriteAddr),
    .outWrite   (resOutWrite),
    .wbWrite    (wbWrite),
    .wbAddr     (wbAddr),
    .wbData     (wbData),
    .outputPort (outputPort),
    .outStrobe  (outStrobe)
  );

endmodule

// File: bench/processorTests.svh
// register form with dest, srcA and srcB fields
function automatic cpuPkg::instr_t regInstr(cpuPkg::opcode_t op, int d, int a, int b);
  cpuPkg::instr_t w;
  w = '0;
  w[cpuPkg::opcodeHi:cpuPkg::opcodeLo] = op;
  w[cpuPkg::destHi:cpuPkg::destLo]     = 3'(d);
  w[cpuPkg::srcAHi:cpuPkg::srcALo]     = 3'(a);
  w[cpuPkg::srcBHi:cpuPkg::srcBLo]     = 3'(b);
  return w;
endfunction

function automatic cpuPkg::instr_t immInstr(cpuPkg::opcode_t op, int d, int imm);
  cpuPkg::instr_t w;
  w = '0;
  w[cpuPkg::opcodeHi:cpuPkg::opcodeLo] = op;
  w[cpuPkg::destHi:cpuPkg::destLo]     = 3'(d);
  w[cpuPkg::immHi:cpuPkg::immLo]       = 8'(imm);
  return w;
endfunction

function automatic cpuPkg::instr_t shiftInstr(cpuPkg::opcode_t op, int d, int a, int amt);
  cpuPkg::instr_t w;
  w = '0;
  w[cpuPkg::opcodeHi:cpuPkg::opcodeLo] = op;
  w[cpuPkg::destHi:cpuPkg::destLo]     = 3'(d);
  w[cpuPkg::srcAHi:cpuPkg::srcALo]     = 3'(a);
  w[cpuPkg::shiftHi:cpuPkg::shiftLo]   = 4'(amt);
  return w;
endfunction

task automatic resetModel();
  prog.delete();
  expectOut.delete();
  foreach (modelRegs[i])
  begin
    modelRegs[i] = '0;
  end
  modelCcr = '0;
endtask

// run one instruction on the model, then append it with two spacer nops
task automatic emit(input cpuPkg::instr_t w);
  cpuPkg::opcode_t op;
  int              d;
  int              amt;
  cpuPkg::word_t   x;
  cpuPkg::word_t   y;
  cpuPkg::word_t   r;
  logic            c;
  logic            isAlu;
  op    = cpuPkg::opcode_t'(w[cpuPkg::opcodeHi:cpuPkg::opcodeLo]);
  d     = w[cpuPkg::destHi:cpuPkg::destLo];
  amt   = w[cpuPkg::shiftHi:cpuPkg::shiftLo];
  x     = modelRegs[w[cpuPkg::srcAHi:cpuPkg::srcALo]];
  y     = modelRegs[w[cpuPkg::srcBHi:cpuPkg::srcBLo]];
  r     = '0;
  c     = 1'b0;
  isAlu = 1'b1;
  case (op)
    cpuPkg::opAdd:
    begin
      r = x + y;
      // true sum past 16 bits
      c = (int'(x) + int'(y)) > 65535;
    end
    cpuPkg::opSub:
    begin
      r = x - y;
      // borrow
      c = x < y;
    end
    cpuPkg::opAnd: r = x & y;
    cpuPkg::opOr:  r = x | y;
    cpuPkg::opNot: r = ~x;
    cpuPkg::opInc: r = x + 16'd1;
    cpuPkg::opShl:
    begin
      r = x << amt;
      // last bit pushed out the top
      if (amt != 0)
      begin
        c = x[16 - amt];
      end
    end
    cpuPkg::opShr: r = x >> amt;
    default:       isAlu = 1'b0;
  endcase
  if (isAlu)
  begin
    modelRegs[d] = r;
    modelCcr     = {r == 16'h0000, r[15], c};
  end
  else
  begin
    case (op)
      cpuPkg::opMov:   modelRegs[d] = x;
      cpuPkg::opLdi:   modelRegs[d] = {8'h00, w[7:0]};
      cpuPkg::opIn:    modelRegs[d] = inValue;
      cpuPkg::opOut:   expectOut.push_back(x);
      cpuPkg::opLoad:  modelRegs[d] = modelMem[x[dmemAw-1:0]];
      cpuPkg::opStore: modelMem[x[dmemAw-1:0]] = y;
      default:         ;
    endcase
  end
  prog.push_back(w);
  if (op != cpuPkg::opHalt)
  begin
    prog.push_back(16'h0000);
    prog.push_back(16'h0000);
  end
endtask

// builds a full 16-bit constant and clobbers tmp
task automatic loadConst(input int d, input int tmp, input cpuPkg::word_t value);
  emit(immInstr(cpuPkg::opLdi, d, value[15:8]));
  emit(shiftInstr(cpuPkg::opShl, d, d, 8));
  emit(immInstr(cpuPkg::opLdi, tmp, value[7:0]));
  emit(regInstr(cpuPkg::opOr, d, d, tmp));
endtask

task automatic loadMoveOut();
  resetModel();
  // r0 still zero from reset, out first for the latency check
  emit(regInstr(cpuPkg::opOut, 0, 0, 0));
  emit(immInstr(cpuPkg::opLdi, 1, 8'h5a));
  emit(immInstr(cpuPkg::opLdi, 2, 8'hc3));
  emit(regInstr(cpuPkg::opMov, 3, 1, 0));
  emit(regInstr(cpuPkg::opOut, 0, 1, 0));
  emit(regInstr(cpuPkg::opOut, 0, 3, 0));
  emit(regInstr(cpuPkg::opMov, 4, 2, 0));
  emit(regInstr(cpuPkg::opOut, 0, 4, 0));
  // zero values through ldi and mov must leave ccr alone
  emit(immInstr(cpuPkg::opLdi, 5, 8'h00));
  emit(regInstr(cpuPkg::opMov, 6, 0, 0));
  emit(regInstr(cpuPkg::opHalt, 0, 0, 0));
  runProgram();
  checkOutputs();
  checkCcr();
  checkValue("first outStrobe cycle", 5, firstStrobe);
endtask

task automatic aluOperations();
  cpuPkg::word_t hi;
  cpuPkg::word_t lo;
  for (int run = 0; run < 2; run++)
  begin
    // both top bits set so the sum carries, lo below hi so lo - hi borrows
    hi = 16'($random(seed)) | 16'hc000;
    lo = (16'($random(seed)) & 16'h3fff) | 16'h8000;
    resetModel();
    loadConst(1, 7, hi);
    loadConst(2, 7, lo);
    emit(regInstr(cpuPkg::opAnd, 3, 1, 2));
    emit(regInstr(cpuPkg::opOr, 4, 1, 2));
    emit(regInstr(cpuPkg::opNot, 5, 1, 0));
    emit(regInstr(cpuPkg::opInc, 6, 2, 0));
    for (int r = 3; r <= 6; r++)
    begin
      emit(regInstr(cpuPkg::opOut, 0, r, 0));
    end
    // first run leaves ccr from the borrow, second from the carry
    if (run == 0)
    begin
      emit(regInstr(cpuPkg::opAdd, 3, 1, 2));
      emit(regInstr(cpuPkg::opSub, 4, 2, 1));
    end
    else
    begin
      emit(regInstr(cpuPkg::opSub, 4, 2, 1));
      emit(regInstr(cpuPkg::opAdd, 3, 1, 2));
    end
    emit(regInstr(cpuPkg::opOut, 0, 3, 0));
    emit(regInstr(cpuPkg::opOut, 0, 4, 0));
    emit(regInstr(cpuPkg::opHalt, 0, 0, 0));
    runProgram();
    checkOutputs();
    checkCcr();
  end
endtask

task automatic shiftOperations();
  cpuPkg::word_t v;
  int amounts [5] = '{0, 1, 4, 8, 15};
  // bit 11 set so a shift left by 5 carries out a one
  v = 16'($random(seed)) | 16'h0800;
  resetModel();
  loadConst(1, 7, v);
  foreach (amounts[i])
  begin
    emit(shiftInstr(cpuPkg::opShl, 2, 1, amounts[i]));
    emit(regInstr(cpuPkg::opOut, 0, 2, 0));
    emit(shiftInstr(cpuPkg::opShr, 3, 1, amounts[i]));
    emit(regInstr(cpuPkg::opOut, 0, 3, 0));
  end
  emit(shiftInstr(cpuPkg::opShl, 4, 1, 5));
  emit(regInstr(cpuPkg::opOut, 0, 4, 0));
  emit(regInstr(cpuPkg::opHalt, 0, 0, 0));
  runProgram();
  checkOutputs();
  checkCcr();
endtask

task automatic inputPortEcho();
  // port held for the whole run
  inValue   = 16'($random(seed));
  inputPort = inValue;
  resetModel();
  emit(regInstr(cpuPkg::opIn, 1, 0, 0));
  emit(regInstr(cpuPkg::opOut, 0, 1, 0));
  emit(regInstr(cpuPkg::opIn, 2, 0, 0));
  emit(regInstr(cpuPkg::opNot, 3, 2, 0));
  emit(regInstr(cpuPkg::opOut, 0, 3, 0));
  emit(regInstr(cpuPkg::opHalt, 0, 0, 0));
  runProgram();
  checkOutputs();
  checkCcr();
endtask

task automatic memoryReadback();
  logic [7:0] addrs [4] = '{8'h03, 8'h41, 8'h9c, 8'hff};
  int         order [4] = '{2, 0, 3, 1};
  resetModel();
  foreach (addrs[i])
  begin
    emit(immInstr(cpuPkg::opLdi, 1, addrs[i]));
    loadConst(2, 7, 16'($random(seed)));
    emit(regInstr(cpuPkg::opStore, 0, 1, 2));
  end
  // read back shuffled
  foreach (order[i])
  begin
    emit(immInstr(cpuPkg::opLdi, 1, addrs[order[i]]));
    emit(regInstr(cpuPkg::opLoad, 3, 1, 0));
    emit(regInstr(cpuPkg::opOut, 0, 3, 0));
  end
  emit(regInstr(cpuPkg::opHalt, 0, 0, 0));
  runProgram();
  checkOutputs();
  checkCcr();
endtask

task automatic haltAndRestart();
  resetModel();
  emit(immInstr(cpuPkg::opLdi, 1, 8'h81));
  emit(regInstr(cpuPkg::opNot, 2, 1, 0));
  emit(regInstr(cpuPkg::opOut, 0, 2, 0));
  emit(regInstr(cpuPkg::opHalt, 0, 0, 0));
  // words past halt must never issue
  emit(regInstr(cpuPkg::opOut, 0, 1, 0));
  runProgram();
  expectOut.delete();
  expectOut.push_back(16'hff7e);
  checkOutputs();
  checkValue("ccr", 3'b010, ccr);
  for (int i = 0; i < quietCycles; i++)
  begin
    nextCycle();
    checkValue("outStrobe", 1'b0, outStrobe);
  end
  resetDut();
  checkValue("halted", 1'b0, halted);
  checkValue("outputPort", 16'h0000, outputPort);
  checkValue("ccr", 3'b000, ccr);
  // second program after the reset
  resetModel();
  emit(immInstr(cpuPkg::opLdi, 5, 8'h3c));
  emit(regInstr(cpuPkg::opInc, 6, 5, 0));
  emit(regInstr(cpuPkg::opOut, 0, 6, 0));
  emit(regInstr(cpuPkg::opOut, 0, 5, 0));
  emit(regInstr(cpuPkg::opHalt, 0, 0, 0));
  runProgram();
  checkOutputs();
  checkCcr();
endtask

// File: bench/processorTb.sv
`timescale 1ns/10ps

module processorTb;

  localparam int imemAw = 8;
  localparam int dmemAw = 8;
  // cycles a program gets to reach halt
  localparam int runLimit = 1000;
  // last strobes can trail halted by a cycle
  localparam int drainCycles = 3;
  localparam int quietCycles = 20;

  logic              clk;
  logic              rst;
  logic              start;
  logic              progWrite;
  logic [imemAw-1:0] progAddr;
  cpuPkg::instr_t    progData;
  cpuPkg::word_t     inputPort;
  cpuPkg::word_t     outputPort;
  logic              outStrobe;
  cpuPkg::ccr_t      ccr;
  logic              halted;

  // program image, expected and observed output streams
  cpuPkg::instr_t prog [$];
  cpuPkg::word_t  expectOut [$];
  cpuPkg::word_t  gotOut [$];

  // reference model state
  cpuPkg::word_t  modelRegs [8];
  cpuPkg::word_t  modelMem [2**dmemAw];
  cpuPkg::ccr_t   modelCcr;
  cpuPkg::word_t  inValue;

  integer seed;
  int     errors;
  int     checks;
  int     firstStrobe;
  logic   timedOut;

  processor #(
    .imemAddrWidth (imemAw),
    .dmemAddrWidth (dmemAw)
  ) i_processor (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .progWrite  (progWrite),
    .progAddr   (progAddr),
    .progData   (progData),
    .inputPort  (inputPort),
    .outputPort (outputPort),
    .outStrobe  (outStrobe),
    .ccr        (ccr),
    .halted     (halted)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // inputs change and outputs are read just after the edge
  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic resetDut();
    rst       = 1'b1;
    start     = 1'b0;
    progWrite = 1'b0;
    repeat (3) nextCycle();
    rst = 1'b0;
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic captureStrobe(input int cycle);
    if (outStrobe)
    begin
      if (gotOut.size() == 0)
      begin
        firstStrobe = cycle;
      end
      gotOut.push_back(outputPort);
    end
  endtask

  // reset, load prog through the loader, start, collect strobes up to halt
  task automatic runProgram();
    int cycles;
    resetDut();
    for (int i = 0; i < prog.size(); i++)
    begin
      progWrite = 1'b1;
      progAddr  = imemAw'(i);
      progData  = prog[i];
      nextCycle();
    end
    progWrite = 1'b0;
    start     = 1'b1;
    gotOut.delete();
    firstStrobe = 0;
    cycles      = 0;
    while (!halted && cycles < runLimit)
    begin
      nextCycle();
      // one sample in idle is enough
      start = 1'b0;
      cycles++;
      captureStrobe(cycles);
    end
    if (!halted)
    begin
      errors++;
      timedOut = 1'b1;
      $display("Timeout at %0t: halted did not rise within %0d cycles", $time, runLimit);
    end
    else
    begin
      for (int i = 0; i < drainCycles; i++)
      begin
        nextCycle();
        cycles++;
        captureStrobe(cycles);
      end
    end
  endtask

  task automatic checkOutputs();
    checkValue("outStrobe count", expectOut.size(), gotOut.size());
    for (int i = 0; i < expectOut.size() && i < gotOut.size(); i++)
    begin
      checkValue($sformatf("outputPort[%0d]", i), expectOut[i], gotOut[i]);
    end
  endtask

  task automatic checkCcr();
    checkValue("ccr", modelCcr, ccr);
  endtask

  `include "processorTests.svh"

  initial
  begin
    seed      = 32'he0c3;
    rst       = 1'b1;
    start     = 1'b0;
    progWrite = 1'b0;
    progAddr  = '0;
    progData  = '0;
    inputPort = '0;
    inValue   = '0;
    errors    = 0;
    checks    = 0;
    timedOut  = 1'b0;
    loadMoveOut();
    if (!timedOut)
    begin
      aluOperations();
    end
    if (!timedOut)
    begin
      shiftOperations();
    end
    if (!timedOut)
    begin
      inputPortEcho();
    end
    if (!timedOut)
    begin
      memoryReadback();
    end
    if (!timedOut)
    begin
      haltAndRestart();
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+bench
hw/cpuPkg.sv
hw/regFile.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/resultStage.sv
hw/processor.sv
bench/processorTb.sv
